//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f tb.f --top-module proc_tb -Mdir obj_dir
	./obj_dir/Vproc_tb

clean:
	rm -rf obj_dir

//--- source/control.sv
`timescale 1ns/1ns
`default_nettype none
`include "proc_params.svh"

module control (
    input  wire  [`DATA_W-1:0]   instr,
    output logic                 regWrite,
    output logic                 regDst,
    output logic                 aluSrc,
    output logic                 zeroExt,
    output logic                 memWrite,
    output logic                 memRead,
    output logic                 memToReg,
    output proc_pkg::branchCondT branchCond,
    output logic                 jump,
    output proc_pkg::aluOpT      aluOp,
    output logic                 halt,
    output logic                 illegal
);

    proc_pkg::opcodeT opcode;

    assign opcode = proc_pkg::opcodeT'(instr[15:11]);

    always_comb begin
        // Everything off unless the opcode asks for it
        regWrite   = 1'b0;
        regDst     = 1'b0;
        aluSrc     = 1'b0;
        zeroExt    = 1'b0;
        memWrite   = 1'b0;
        memRead    = 1'b0;
        memToReg   = 1'b0;
        branchCond = proc_pkg::brNone;
        jump       = 1'b0;
        aluOp      = proc_pkg::aluAdd;
        halt       = 1'b0;
        illegal    = 1'b0;
        case (opcode)
            proc_pkg::opHalt: halt = 1'b1;
            proc_pkg::opNop: begin
                // No state changes
            end
            proc_pkg::opAddi, proc_pkg::opSubi, proc_pkg::opXori, proc_pkg::opAndni: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                // Immediate ops share the funct encoding in opcode bits 1:0
                aluOp    = proc_pkg::aluOpT'({1'b0, instr[12:11]});
                zeroExt  = instr[12];
            end
            proc_pkg::opSt: begin
                aluSrc   = 1'b1;
                memWrite = 1'b1;
            end
            proc_pkg::opLd: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                memRead  = 1'b1;
                memToReg = 1'b1;
            end
            proc_pkg::opAlu: begin
                regWrite = 1'b1;
                regDst   = 1'b1;
                aluOp    = proc_pkg::aluOpT'({1'b0, instr[1:0]});
            end
            proc_pkg::opBeqz: branchCond = proc_pkg::brEqz;
            proc_pkg::opBnez: branchCond = proc_pkg::brNez;
            proc_pkg::opBltz: branchCond = proc_pkg::brLtz;
            proc_pkg::opLbi: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = proc_pkg::aluPassB;
            end
            proc_pkg::opJ: jump = 1'b1;
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- source/decode.sv
`timescale 1ns/1ns
`default_nettype none
`include "proc_params.svh"

module decode (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire  [`DATA_W-1:0]   instr,
    input  wire                  regDst,
    input  wire                  regWrite,
    input  wire  [`DATA_W-1:0]   writeData,
    output logic [`DATA_W-1:0]   read1Data,
    output logic [`DATA_W-1:0]   read2Data,
    output logic [`DATA_W-1:0]   extImm,
    output logic [`REG_AW-1:0]   writeReg
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];
    proc_pkg::opcodeT   opcode;
    logic [`REG_AW-1:0] rs;
    logic [`REG_AW-1:0] rt;

    assign opcode = proc_pkg::opcodeT'(instr[15:11]);
    assign rs     = instr[10:8];
    assign rt     = instr[7:5];

    // LBI writes its rs field, R format uses bits 4:2, I1 format bits 7:5
    always_comb begin
        if (opcode == proc_pkg::opLbi) begin
            writeReg = rs;
        end else if (regDst) begin
            writeReg = instr[4:2];
        end else begin
            writeReg = rt;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite) begin
            regs[writeReg] <= writeData;
        end
    end

    // Port 2 reads bits 7:5, which is also the ST data register
    assign read1Data = regs[rs];
    assign read2Data = regs[rt];

    always_comb begin
        case (opcode)
            proc_pkg::opXori, proc_pkg::opAndni:
                extImm = {{(`DATA_W-5){1'b0}}, instr[4:0]};
            proc_pkg::opLbi, proc_pkg::opBeqz, proc_pkg::opBnez, proc_pkg::opBltz:
                extImm = {{(`DATA_W-8){instr[7]}}, instr[7:0]};
            proc_pkg::opJ:
                extImm = {{(`DATA_W-11){instr[10]}}, instr[10:0]};
            default:
                extImm = {{(`DATA_W-5){instr[4]}}, instr[4:0]};
        endcase
    end

endmodule

`default_nettype wire

//--- source/execute.sv
`timescale 1ns/1ns
`default_nettype none
`include "proc_params.svh"

module execute (
    input  wire  [`DATA_W-1:0]   read1Data,
    input  wire  [`DATA_W-1:0]   read2Data,
    input  wire  [`DATA_W-1:0]   extImm,
    input  wire                  aluSrc,
    input  wire proc_pkg::aluOpT aluOp,
    input  wire                  jump,
    input  wire  [`DATA_W-1:0]   instr,
    input  wire  [`DATA_W-1:0]   pcPlusOne,
    output logic [`DATA_W-1:0]   aluRes,
    output logic [`DATA_W-1:0]   target
);

    logic [`DATA_W-1:0] opB;
    logic [`DATA_W-1:0] disp;

    // Operand B is rt or the extended immediate
    assign opB = aluSrc ? extImm : read2Data;

    always_comb begin
        case (aluOp)
            proc_pkg::aluAdd: begin
                aluRes = read1Data + opB;
            end
            proc_pkg::aluSub: begin
                aluRes = opB - read1Data;
            end
            proc_pkg::aluXor: begin
                aluRes = read1Data ^ opB;
            end
            proc_pkg::aluAndn: begin
                aluRes = read1Data & ~opB;
            end
            proc_pkg::aluPassB: begin
                aluRes = opB;
            end
            default: begin
                aluRes = opB;
            end
        endcase
    end

    // Branches carry imm8, J carries disp11
    always_comb begin
        if (jump) begin
            disp = {{(`DATA_W-11){instr[10]}}, instr[10:0]};
        end else begin
            disp = {{(`DATA_W-8){instr[7]}}, instr[7:0]};
        end
    end

    // Relative to the instruction after this one
    assign target = pcPlusOne + disp;

endmodule

`default_nettype wire

//--- source/fetch.sv
`timescale 1ns/1ns
`default_nettype none
`include "proc_params.svh"

module fetch (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire                  progWe,
    input  wire  [`MEM_AW-1:0]   progAddr,
    input  wire  [`DATA_W-1:0]   progData,
    input  wire  [`DATA_W-1:0]   nextPc,
    input  wire                  stop,
    input  wire                  errIn,
    output logic [`DATA_W-1:0]   instr,
    output logic [`DATA_W-1:0]   pc,
    output logic [`DATA_W-1:0]   pcPlusOne,
    output logic                 halted,
    output logic                 err
);

    logic [`DATA_W-1:0] imem [`IMEM_DEPTH];

    // Program load port, only live while the core is held in reset
    always_ff @(posedge clk) begin
        if (!rstN && progWe) begin
            imem[progAddr] <= progData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc     <= '0;
            halted <= 1'b0;
            err    <= 1'b0;
        end else if (!halted) begin
            // HALT or an illegal opcode retires and then freezes the PC
            if (stop) begin
                halted <= 1'b1;
                err    <= errIn;
            end else begin
                pc <= nextPc;
            end
        end
    end

    assign pcPlusOne = pc + `DATA_W'(1);
    assign instr     = imem[pc[`MEM_AW-1:0]];

    assert property (@(posedge clk) disable iff (!rstN) halted |=> $stable(pc));

endmodule

`default_nettype wire

//--- source/memory.sv
`timescale 1ns/1ns
`default_nettype none
`include "proc_params.svh"

module memory (
    input  wire                       clk,
    input  wire                       memWrite,
    input  wire                       memRead,
    input  wire                       memToReg,
    input  wire  [`DATA_W-1:0]        aluRes,
    input  wire  [`DATA_W-1:0]        storeData,
    input  wire  [`DATA_W-1:0]        read1Data,
    input  wire proc_pkg::branchCondT branchCond,
    input  wire                       jump,
    input  wire  [`DATA_W-1:0]        target,
    input  wire  [`DATA_W-1:0]        pcPlusOne,
    output logic [`DATA_W-1:0]        writeData,
    output logic [`DATA_W-1:0]        nextPc
);

    logic [`DATA_W-1:0] dmem [`DMEM_DEPTH] = '{default: '0};
    logic [`MEM_AW-1:0] addr;
    logic [`DATA_W-1:0] loadData;
    logic               taken;

    assign addr = aluRes[`MEM_AW-1:0];

    always_ff @(posedge clk) begin
        if (memWrite) begin
            dmem[addr] <= storeData;
        end
    end

    // Asynchronous read, valid in the same cycle as the address
    assign loadData = memRead ? dmem[addr] : '0;

    // Branch condition tests rs against zero
    always_comb begin
        case (branchCond)
            proc_pkg::brEqz: taken = (read1Data == '0);
            proc_pkg::brNez: taken = (read1Data != '0);
            proc_pkg::brLtz: taken = read1Data[`DATA_W-1];
            default:         taken = 1'b0;
        endcase
    end

    assign nextPc    = (taken || jump) ? target : pcPlusOne;
    assign writeData = memToReg ? loadData : aluRes;

    assert property (@(posedge clk) memWrite |-> !$isunknown(addr));

endmodule

`default_nettype wire

//--- source/proc.sv
`timescale 1ns/1ns
`default_nettype none
`include "proc_params.svh"

module proc (
    input  wire                  clk,
    input  wire                  rstN,
    input  wire                  progWe,
    input  wire  [`MEM_AW-1:0]   progAddr,
    input  wire  [`DATA_W-1:0]   progData,
    output logic                 halted,
    output logic                 err,
    output logic                 retireValid,
    output logic [`DATA_W-1:0]   retirePc,
    output logic                 wbEn,
    output logic [`REG_AW-1:0]   wbReg,
    output logic [`DATA_W-1:0]   wbData,
    output logic                 memWe,
    output logic [`MEM_AW-1:0]   memAddr,
    output logic [`DATA_W-1:0]   memData
);

    logic [`DATA_W-1:0]   instr, pc, pcPlusOne, nextPc;
    logic                 regWrite, regDst, aluSrc, zeroExt;
    logic                 memWrite, memRead, memToReg, jump, halt, illegal;
    proc_pkg::branchCondT branchCond;
    proc_pkg::aluOpT      aluOp;
    logic [`DATA_W-1:0]   read1Data, read2Data, extImm;
    logic [`DATA_W-1:0]   aluRes, target, writeData;
    logic [`REG_AW-1:0]   writeReg;
    logic                 run;

    // One instruction retires per cycle once out of reset and until halted
    assign run = rstN && !halted;

    fetch fetch0 (.clk(clk), .rstN(rstN), .progWe(progWe), .progAddr(progAddr),
                  .progData(progData), .nextPc(nextPc), .stop(halt || illegal),
                  .errIn(illegal), .instr(instr), .pc(pc), .pcPlusOne(pcPlusOne),
                  .halted(halted), .err(err));

    control control0 (.instr(instr), .regWrite(regWrite), .regDst(regDst),
                      .aluSrc(aluSrc), .zeroExt(zeroExt), .memWrite(memWrite),
                      .memRead(memRead), .memToReg(memToReg), .branchCond(branchCond),
                      .jump(jump), .aluOp(aluOp), .halt(halt), .illegal(illegal));

    decode decode0 (.clk(clk), .rstN(rstN), .instr(instr), .regDst(regDst),
                    .regWrite(wbEn), .writeData(writeData), .read1Data(read1Data),
                    .read2Data(read2Data), .extImm(extImm), .writeReg(writeReg));

    execute execute0 (.read1Data(read1Data), .read2Data(read2Data), .extImm(extImm),
                      .aluSrc(aluSrc), .aluOp(aluOp), .jump(jump), .instr(instr),
                      .pcPlusOne(pcPlusOne), .aluRes(aluRes), .target(target));

    memory memory0 (.clk(clk), .memWrite(memWe), .memRead(memRead), .memToReg(memToReg),
                    .aluRes(aluRes), .storeData(read2Data), .read1Data(read1Data),
                    .branchCond(branchCond), .jump(jump), .target(target),
                    .pcPlusOne(pcPlusOne), .writeData(writeData), .nextPc(nextPc));

    // State-changing strobes, gated here only
    assign wbEn        = run && regWrite;
    assign memWe       = run && memWrite;
    assign retireValid = run;

    assign retirePc = pc;
    assign wbReg    = writeReg;
    assign wbData   = writeData;
    assign memAddr  = aluRes[`MEM_AW-1:0];
    assign memData  = read2Data;

    // XORI and ANDNI must reach the ALU zero-extended
    assert property (@(posedge clk) disable iff (!rstN)
        zeroExt |-> (extImm[`DATA_W-1:5] == '0));

endmodule

`default_nettype wire

//--- source/proc_params.svh
`ifndef PROC_PARAMS_SVH
`define PROC_PARAMS_SVH

// Data path and instruction word width
`define DATA_W 16

// Register file size and index width
`define REG_COUNT 8
`define REG_AW 3

// Word-addressed memories
`define IMEM_DEPTH 256
`define DMEM_DEPTH 256

// Memory addresses are the low bits of a data word
`define MEM_AW 8

`endif

//--- source/proc_pkg.sv
`default_nettype none

package proc_pkg;

    // Primary opcode in instruction bits 15:11
    typedef enum logic [4:0] {
        opHalt  = 5'b00000,
        opNop   = 5'b00001,
        opJ     = 5'b00100,
        opAddi  = 5'b01000,
        opSubi  = 5'b01001,
        opXori  = 5'b01010,
        opAndni = 5'b01011,
        opBeqz  = 5'b01100,
        opBnez  = 5'b01101,
        opBltz  = 5'b01110,
        opSt    = 5'b10000,
        opLd    = 5'b10001,
        opLbi   = 5'b11000,
        opAlu   = 5'b11011
    } opcodeT;

    // Operand A is rs, operand B is rt or the immediate
    // Low two bits line up with the R-format funct field
    typedef enum logic [2:0] {
        aluAdd   = 3'd0,
        aluSub   = 3'd1,  // B minus A
        aluXor   = 3'd2,
        aluAndn  = 3'd3,  // A and not B
        aluPassB = 3'd4
    } aluOpT;

    typedef enum logic [1:0] {
        brEqz  = 2'd0,
        brNez  = 2'd1,
        brLtz  = 2'd2,
        brNone = 2'd3
    } branchCondT;

endpackage

`default_nettype wire

//--- tb.f
+incdir+source
+incdir+verif
source/proc_pkg.sv
source/fetch.sv
source/control.sv
source/decode.sv
source/execute.sv
source/memory.sv
source/proc.sv
verif/proc_tb.sv

//--- verif/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Program image, indexed by the low 6 bits of the PC
logic [15:0] prog [64];
int          progLen;

// Reference architectural state, data memory persists across resets like the DUT's
logic [15:0] modelRegs [8];
logic [15:0] modelMem [256];
logic [15:0] modelPc;

// Expected retire of the instruction just stepped
logic        expWb, expMemWe, expStop, expErr;
logic [2:0]  expReg;
logic [7:0]  expAddr;
logic [15:0] expData, expStore;

// Body opcode mix with ALU ops weighted up, LD is emitted right after ST
proc_pkg::opcodeT opMix [16] = '{
    proc_pkg::opAddi, proc_pkg::opSubi, proc_pkg::opXori, proc_pkg::opAndni,
    proc_pkg::opAlu, proc_pkg::opAlu, proc_pkg::opAlu, proc_pkg::opLbi,
    proc_pkg::opLbi, proc_pkg::opSt, proc_pkg::opBeqz, proc_pkg::opBnez,
    proc_pkg::opBltz, proc_pkg::opJ, proc_pkg::opNop, proc_pkg::opAddi
};

task automatic genProgram(input bit endIllegal);
    int               i;
    int               room;
    logic [15:0]      r;
    logic [15:0]      rtPick;
    proc_pkg::opcodeT op;
    progLen = 8 + int'(randomBits(6)) % (MaxProgLen - 7);
    // Registers are clear after reset so this ADD must write zero
    r = randomBits(16);
    prog[0] = {proc_pkg::opAlu, r[10:2], 2'b00};
    i = 1;
    while (i < progLen - 1) begin
        r = randomBits(16);
        op = opMix[r[15:12]];
        room = progLen - 2 - i;
        prog[i[5:0]] = {op, r[10:0]};
        // Forward targets only, never past the last word
        if (op == proc_pkg::opJ) begin
            prog[i[5:0]][10:0] = 11'(int'(r[10:0]) % (room + 1));
        end else if (op == proc_pkg::opBeqz || op == proc_pkg::opBnez
                || op == proc_pkg::opBltz) begin
            prog[i[5:0]][7:0] = 8'(int'(r[7:0]) % (room + 1));
        end else if (op == proc_pkg::opSt && room > 0) begin
            i++;
            rtPick = randomBits(3);
            prog[i[5:0]] = {proc_pkg::opLd, r[10:8], rtPick[2:0], r[4:0]};
        end
        i++;
    end
    if (endIllegal) begin
        prog[i[5:0]] = {5'b11111, r[10:0]};
    end else begin
        prog[i[5:0]] = {proc_pkg::opHalt, 11'd0};
    end
endtask

// Executes the word at modelPc and sets the expected retire fields
task automatic modelStep();
    logic [15:0]      ins;
    logic [15:0]      a;
    logic [15:0]      b;
    logic [15:0]      se5;
    logic [15:0]      ze5;
    logic [15:0]      se8;
    logic [15:0]      ea;
    logic [15:0]      aluR;
    logic [15:0]      brTarget;
    logic [15:0]      nextPc;
    proc_pkg::opcodeT op;
    ins      = prog[modelPc[5:0]];
    op       = proc_pkg::opcodeT'(ins[15:11]);
    a        = modelRegs[ins[10:8]];
    b        = modelRegs[ins[7:5]];
    se5      = {{11{ins[4]}}, ins[4:0]};
    ze5      = {11'd0, ins[4:0]};
    se8      = {{8{ins[7]}}, ins[7:0]};
    ea       = a + se5;
    // Funct 0 add, 1 rt minus rs, 2 xor, 3 rs and not rt
    aluR     = (ins[1:0] == 2'd0) ? a + b : (ins[1:0] == 2'd1) ? b - a :
               (ins[1:0] == 2'd2) ? a ^ b : a & ~b;
    brTarget = modelPc + 16'd1 + se8;
    nextPc   = modelPc + 16'd1;
    expWb    = 1'b0;
    expReg   = ins[7:5];
    expData  = '0;
    expMemWe = 1'b0;
    expAddr  = ea[7:0];
    expStore = b;
    expStop  = 1'b0;
    expErr   = 1'b0;
    case (op)
        proc_pkg::opAddi:  {expWb, expData} = {1'b1, a + se5};
        proc_pkg::opSubi:  {expWb, expData} = {1'b1, se5 - a};
        proc_pkg::opXori:  {expWb, expData} = {1'b1, a ^ ze5};
        proc_pkg::opAndni: {expWb, expData} = {1'b1, a & ~ze5};
        proc_pkg::opAlu:   {expWb, expReg, expData} = {1'b1, ins[4:2], aluR};
        proc_pkg::opLbi:   {expWb, expReg, expData} = {1'b1, ins[10:8], se8};
        proc_pkg::opLd:    {expWb, expData} = {1'b1, modelMem[expAddr]};
        proc_pkg::opSt:    expMemWe = 1'b1;
        proc_pkg::opBeqz:  nextPc = (a == 16'd0) ? brTarget : nextPc;
        proc_pkg::opBnez:  nextPc = (a != 16'd0) ? brTarget : nextPc;
        proc_pkg::opBltz:  nextPc = a[15] ? brTarget : nextPc;
        proc_pkg::opJ:     nextPc = modelPc + 16'd1 + {{5{ins[10]}}, ins[10:0]};
        proc_pkg::opNop, proc_pkg::opHalt: expStop = (op == proc_pkg::opHalt);
        default:           {expStop, expErr} = 2'b11;
    endcase
    if (expWb) begin
        modelRegs[expReg] = expData;
    end
    if (expMemWe) begin
        modelMem[expAddr] = expStore;
    end
    modelPc = nextPc;
endtask

`endif

//--- verif/proc_tb.sv
`timescale 1ns/1ns
`default_nettype none

module proc_tb;

    localparam int NumPrograms = 20;
    localparam int MaxProgLen  = 48;
    localparam int HaltCycles  = 10;
    // Longest load, reset, run and parked check, for every program
    localparam int MaxCycles   = NumPrograms * (MaxProgLen + 5 + MaxProgLen + HaltCycles);

    logic        clk = 1'b0;
    logic        rstN, progWe, halted, err, retireValid, wbEn, memWe;
    logic [2:0]  wbReg;
    logic [7:0]  progAddr, memAddr;
    logic [15:0] progData, retirePc, wbData, memData;
    logic [31:0] lfsrState = 32'h6705ed49;
    int          cycleCount = 0;

    proc u_proc (.*);

    always #20 clk = ~clk;

    // Fibonacci LFSR on taps 32 22 2 1
    function automatic logic [15:0] randomBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            v = {v[14:0], lfsrState[0]};
        end
        return v;
    endfunction

    `include "isa_model.svh"

    task automatic checkValue(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    // Program words go in while reset is held, then five more reset cycles
    task automatic loadProgram();
        @(posedge clk);
        rstN <= 1'b0;
        for (int k = 0; k < progLen; k++) begin
            progWe   <= 1'b1;
            progAddr <= k[7:0];
            progData <= prog[k[5:0]];
            @(posedge clk);
        end
        progWe <= 1'b0;
        repeat (5) @(posedge clk);
        rstN <= 1'b1;
    endtask

    task automatic runProgram();
        modelPc = '0;
        for (int k = 0; k < 8; k++) begin
            modelRegs[k[2:0]] = '0;
        end
        expStop = 1'b0;
        while (!expStop) begin
            @(negedge clk);
            checkValue("retireValid", 16'(retireValid), 16'd1);
            checkValue("retirePc", retirePc, modelPc);
            modelStep();
            checkValue("wbEn", 16'(wbEn), 16'(expWb));
            if (expWb) begin
                checkValue("wbReg", 16'(wbReg), 16'(expReg));
                checkValue("wbData", wbData, expData);
            end
            checkValue("memWe", 16'(memWe), 16'(expMemWe));
            if (expMemWe) begin
                checkValue("memAddr", 16'(memAddr), 16'(expAddr));
                checkValue("memData", memData, expStore);
            end
        end
        // Parked core, err only after an illegal opcode
        repeat (HaltCycles) begin
            @(negedge clk);
            checkValue("retireValid", 16'(retireValid), 16'd0);
            checkValue("halted", 16'(halted), 16'd1);
            checkValue("err", 16'(err), 16'(expErr));
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= MaxCycles) begin
            $display("Timeout after %0d cycles, the core never halted", cycleCount);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        rstN     = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        for (int a = 0; a < 256; a++) begin
            modelMem[a[7:0]] = '0;
        end
        for (int p = 0; p < NumPrograms; p++) begin
            // Every fifth program ends in an illegal opcode instead of HALT
            genProgram(p % 5 == 4);
            loadProgram();
            runProgram();
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
